// ==== design/xm23_settings.svh ====
`ifndef XM23_SETTINGS_SVH
`define XM23_SETTINGS_SVH

`define XM23_WORD_BITS 16
`define XM23_NUM_REGS  8

// Constant table rows selected by RC = 1
`define XM23_CONST_0 16'd0
`define XM23_CONST_1 16'd1
`define XM23_CONST_2 16'd2
`define XM23_CONST_3 16'd4
`define XM23_CONST_4 16'd8
`define XM23_CONST_5 16'd16
`define XM23_CONST_6 16'd32
`define XM23_CONST_7 16'hffff

`endif

// ==== design/xm23_isa_pkg.sv ====
`default_nettype none

package xm23_isa_pkg;

	typedef logic [15:0] instr_t;
	typedef logic [2:0] reg_num_t;
	typedef logic [7:0] imm_byte_t;

	// Major opcode, instr[15:12]; other codes are no-ops
	typedef enum logic [3:0] {
		OP_ADD  = 4'h4,
		OP_SUB  = 4'h5,
		OP_AND  = 4'h6,
		OP_XOR  = 4'h7,
		OP_MOV  = 4'h8,
		OP_SXT  = 4'h9,
		OP_SWPB = 4'ha,
		OP_MOVL = 4'hc,
		OP_MOVH = 4'hd
	} opcode_t;

	// Register/constant format
	typedef struct packed {
		opcode_t opcode;
		logic rc;
		logic byte_mode;
		logic [3:0] spare;
		reg_num_t src;
		reg_num_t dst;
	} alu_fields_t;

	// Immediate byte format (MOVL, MOVH)
	typedef struct packed {
		opcode_t opcode;
		logic spare;
		imm_byte_t imm;
		reg_num_t dst;
	} imm_fields_t;

	function automatic logic op_is_alu(input opcode_t op);
		return (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) ||
			(op == OP_XOR) || (op == OP_MOV);
	endfunction

	function automatic logic op_writes(input opcode_t op);
		return op_is_alu(op) || (op == OP_SXT) || (op == OP_SWPB) ||
			(op == OP_MOVL) || (op == OP_MOVH);
	endfunction

endpackage

`default_nettype wire

// ==== design/xm23_core_pkg.sv ====
`default_nettype none

`include "xm23_settings.svh"

package xm23_core_pkg;
	import xm23_isa_pkg::*;

	typedef logic [`XM23_WORD_BITS-1:0] word_t;

	// Flags high to low: C Z N V
	typedef struct packed {
		logic c;
		logic z;
		logic n;
		logic v;
	} psw_t;

	// Decode to execute
	typedef struct packed {
		opcode_t opcode;
		logic byte_mode;
		reg_num_t dst;
		word_t dst_val;
		word_t src_val;	// Register or constant row
		imm_byte_t imm;
	} dec_payload_t;

	// Execute to writeback
	typedef struct packed {
		reg_num_t dst;
		word_t result;
		psw_t psw;
		logic set_flags;
	} exe_payload_t;

endpackage

`default_nettype wire

// ==== design/xm23_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_stage_reg #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input payload_t in_payload,
	input logic hold,
	output logic out_valid,
	output payload_t out_payload
);

	always_ff @(posedge clock) begin
		if (reset)
			out_valid <= 1'b0;
		else if (!hold)
			out_valid <= in_valid;	// Bubble when nothing arrives
	end

	// Payload only moves with a valid item
	always_ff @(posedge clock) begin
		if (!hold && in_valid)
			out_payload <= in_payload;
	end

endmodule

`default_nettype wire

// ==== design/xm23_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_fetch
	import xm23_isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input instr_t instr,
	input logic instr_req,
	output logic instr_ack,
	output logic fetch_valid,
	output instr_t fetch_instr,
	input logic stall
);

	logic take;
	logic consumed;

	assign take = instr_req && !instr_ack && !fetch_valid;	// Buffer must be empty
	assign consumed = fetch_valid && !stall;

	// Four-phase ack: rise on capture, fall once req drops
	always_ff @(posedge clock) begin
		if (reset) begin
			instr_ack <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			if (take)
				instr_ack <= 1'b1;
			else if (!instr_req)
				instr_ack <= 1'b0;

			if (take)
				fetch_valid <= 1'b1;
			else if (consumed)
				fetch_valid <= 1'b0;	// Decode took it
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			fetch_instr <= instr;
	end

endmodule

`default_nettype wire

// ==== design/xm23_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "xm23_settings.svh"

module xm23_decode
	import xm23_isa_pkg::*, xm23_core_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input instr_t fetch_instr,
	output reg_num_t rd_num_a,
	output reg_num_t rd_num_b,
	input word_t rd_data_a,
	input word_t rd_data_b,
	input logic exe_busy_valid,
	input logic wb_busy_valid,
	input reg_num_t exe_busy_reg,
	input reg_num_t wb_busy_reg,
	output logic stall,
	output logic dec_valid,
	output dec_payload_t dec_payload
);

	localparam word_t CONST_TBL [8] = '{
		`XM23_CONST_0, `XM23_CONST_1, `XM23_CONST_2, `XM23_CONST_3,
		`XM23_CONST_4, `XM23_CONST_5, `XM23_CONST_6, `XM23_CONST_7
	};

	alu_fields_t alu_f;
	imm_fields_t imm_f;
	opcode_t opcode;
	logic writes;
	logic reads_src;
	logic hit_dst;
	logic hit_src;
	dec_payload_t next_payload;

	assign alu_f = alu_fields_t'(fetch_instr);
	assign imm_f = imm_fields_t'(fetch_instr);
	assign opcode = alu_f.opcode;
	assign writes = op_writes(opcode);
	assign reads_src = op_is_alu(opcode) && !alu_f.rc;	// Constant needs no register

	// Port A always reads the destination, port B the source
	assign rd_num_a = alu_f.dst;
	assign rd_num_b = alu_f.src;

	// No forwarding, so any pending write to a read register stalls
	assign hit_dst = writes && ((exe_busy_valid && exe_busy_reg == alu_f.dst) ||
		(wb_busy_valid && wb_busy_reg == alu_f.dst));
	assign hit_src = reads_src && ((exe_busy_valid && exe_busy_reg == alu_f.src) ||
		(wb_busy_valid && wb_busy_reg == alu_f.src));
	assign stall = fetch_valid && (hit_dst || hit_src);

	always_comb begin
		next_payload.opcode = opcode;
		next_payload.byte_mode = alu_f.byte_mode;
		next_payload.dst = alu_f.dst;
		next_payload.dst_val = rd_data_a;
		next_payload.src_val = alu_f.rc ? CONST_TBL[alu_f.src] : rd_data_b;
		next_payload.imm = imm_f.imm;
	end

	// Non-writing opcodes are consumed here and never enter the slot
	xm23_stage_reg #(
		.payload_t(dec_payload_t)
	) exe_slot (
		.clock(clock),
		.reset(reset),
		.in_valid(fetch_valid && !stall && writes),
		.in_payload(next_payload),
		.hold(1'b0),	// Execute never stalls
		.out_valid(dec_valid),
		.out_payload(dec_payload)
	);

endmodule

`default_nettype wire

// ==== design/xm23_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_execute
	import xm23_isa_pkg::*, xm23_core_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic dec_valid,
	input dec_payload_t dec_payload,
	input psw_t psw_cur,
	output logic exe_valid,
	output exe_payload_t exe_payload,
	output reg_num_t exe_busy_reg
);

	word_t d, s, op_b, alu_w, result;
	logic [16:0] sum_w;
	logic [8:0] sum_b;
	logic is_sub, is_arith, set_flags;
	logic msb_d, msb_b, msb_r, carry, zero;
	psw_t psw_base, psw_new;
	exe_payload_t next_payload;

	assign d = dec_payload.dst_val;
	assign s = dec_payload.src_val;
	assign exe_busy_reg = dec_payload.dst;

	assign is_sub = (dec_payload.opcode == OP_SUB);
	assign is_arith = (dec_payload.opcode == OP_ADD) || is_sub;
	assign set_flags = is_arith || (dec_payload.opcode == OP_AND) ||
		(dec_payload.opcode == OP_XOR);

	// SUB is DST + ~SRC + 1
	assign op_b = is_sub ? ~s : s;
	assign sum_w = {1'b0, d} + {1'b0, op_b} + {16'd0, is_sub};
	assign sum_b = {1'b0, d[7:0]} + {1'b0, op_b[7:0]} + {8'd0, is_sub};	// Byte carry

	always_comb begin
		case (dec_payload.opcode)
			OP_ADD, OP_SUB: alu_w = sum_w[15:0];
			OP_AND: alu_w = d & s;
			OP_XOR: alu_w = d ^ s;
			default: alu_w = s;	// MOV
		endcase
	end

	always_comb begin
		case (dec_payload.opcode)
			OP_SXT: result = {{8{d[7]}}, d[7:0]};
			OP_SWPB: result = {d[7:0], d[15:8]};
			OP_MOVL: result = {d[15:8], dec_payload.imm};
			OP_MOVH: result = {dec_payload.imm, d[7:0]};
			default: result = dec_payload.byte_mode ? {d[15:8], alu_w[7:0]} : alu_w;	// Keep high byte
		endcase
	end

	assign msb_d = dec_payload.byte_mode ? d[7] : d[15];
	assign msb_b = dec_payload.byte_mode ? op_b[7] : op_b[15];
	assign msb_r = dec_payload.byte_mode ? result[7] : result[15];
	assign carry = dec_payload.byte_mode ? sum_b[8] : sum_w[16];
	assign zero = dec_payload.byte_mode ? (result[7:0] == 8'd0) : (result == '0);

	// PSW as it stands once the older instruction in writeback lands
	assign psw_base = (exe_valid && exe_payload.set_flags) ? exe_payload.psw : psw_cur;

	always_comb begin
		psw_new = psw_base;	// Logic ops keep C and V
		psw_new.z = zero;
		psw_new.n = msb_r;
		if (is_arith) begin
			psw_new.c = carry;
			psw_new.v = (msb_d == msb_b) && (msb_r != msb_d);
		end
	end

	always_comb begin
		next_payload.dst = dec_payload.dst;
		next_payload.result = result;
		next_payload.psw = psw_new;
		next_payload.set_flags = set_flags;
	end

	xm23_stage_reg #(
		.payload_t(exe_payload_t)
	) wb_slot (
		.clock(clock),
		.reset(reset),
		.in_valid(dec_valid),
		.in_payload(next_payload),
		.hold(1'b0),	// Writeback never stalls
		.out_valid(exe_valid),
		.out_payload(exe_payload)
	);

endmodule

`default_nettype wire

// ==== design/xm23_reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "xm23_settings.svh"

module xm23_reg_file
	import xm23_isa_pkg::*, xm23_core_pkg::*;
(
	input logic clock,
	input logic reset,
	input reg_num_t rd_num_a,
	input reg_num_t rd_num_b,
	output word_t rd_data_a,
	output word_t rd_data_b,
	input logic exe_valid,
	input exe_payload_t exe_payload,
	output logic wb_valid,
	output reg_num_t wb_reg,
	output word_t wb_data,
	output psw_t psw
);

	word_t regs [`XM23_NUM_REGS];

	// Write-first bypass of the word being retired this cycle
	assign rd_data_a = (exe_valid && exe_payload.dst == rd_num_a) ? exe_payload.result :
		regs[rd_num_a];
	assign rd_data_b = (exe_valid && exe_payload.dst == rd_num_b) ? exe_payload.result :
		regs[rd_num_b];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `XM23_NUM_REGS; i++)
				regs[i] <= '0;
			psw <= '0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;	// One pulse per retired write
			if (exe_valid) begin
				regs[exe_payload.dst] <= exe_payload.result;
				if (exe_payload.set_flags)
					psw <= exe_payload.psw;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (exe_valid) begin
			wb_reg <= exe_payload.dst;
			wb_data <= exe_payload.result;
		end
	end

endmodule

`default_nettype wire

// ==== design/xm23_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_core
	import xm23_isa_pkg::*, xm23_core_pkg::*;
(
	input logic clock,
	input logic reset,
	input instr_t instr,
	input logic instr_req,
	output logic instr_ack,
	output logic wb_valid,
	output reg_num_t wb_reg,
	output word_t wb_data,
	output psw_t psw
);

	logic fetch_valid;
	instr_t fetch_instr;
	logic stall;
	reg_num_t rd_num_a, rd_num_b;
	word_t rd_data_a, rd_data_b;
	logic dec_valid;
	dec_payload_t dec_payload;
	logic exe_valid;
	exe_payload_t exe_payload;
	reg_num_t exe_busy_reg;

	xm23_fetch fetch0 (
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.instr_req(instr_req),
		.instr_ack(instr_ack),
		.fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr),
		.stall(stall)
	);

	xm23_decode decode0 (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr),
		.rd_num_a(rd_num_a),
		.rd_num_b(rd_num_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.exe_busy_valid(dec_valid),	// Item in execute
		.wb_busy_valid(exe_valid),	// Item in writeback
		.exe_busy_reg(exe_busy_reg),
		.wb_busy_reg(exe_payload.dst),
		.stall(stall),
		.dec_valid(dec_valid),
		.dec_payload(dec_payload)
	);

	xm23_execute execute0 (
		.clock(clock),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_payload(dec_payload),
		.psw_cur(psw),
		.exe_valid(exe_valid),
		.exe_payload(exe_payload),
		.exe_busy_reg(exe_busy_reg)
	);

	xm23_reg_file reg_file0 (
		.clock(clock),
		.reset(reset),
		.rd_num_a(rd_num_a),
		.rd_num_b(rd_num_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.exe_valid(exe_valid),
		.exe_payload(exe_payload),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.psw(psw)
	);

endmodule

`default_nettype wire

// ==== dv/xm23_core_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_core_sva (
	input logic clock,
	input logic reset,
	input logic instr_req,
	input logic instr_ack,
	input logic wb_valid,
	input logic stall
);

	int fail_count = 0;

	ack_rise_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(instr_ack) |-> $past(instr_req))
		else begin
			$error("instr_ack rose without a pending instr_req");
			fail_count++;
		end

	ack_fall_after_req: assert property (@(posedge clock) disable iff (reset)
		$fell(instr_ack) |-> !$past(instr_req))
		else begin
			$error("instr_ack fell while instr_req was still high");
			fail_count++;
		end

	wb_valid_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(wb_valid))
		else begin
			$error("wb_valid is unknown");
			fail_count++;
		end

	// Fetch buffer is full during a stall
	no_ack_in_stall: assert property (@(posedge clock) disable iff (reset)
		$rose(instr_ack) |-> !$past(stall))
		else begin
			$error("instr_ack rose while decode was stalled");
			fail_count++;
		end

endmodule

bind xm23_core xm23_core_sva sva0 (
	.clock(clock),
	.reset(reset),
	.instr_req(instr_req),
	.instr_ack(instr_ack),
	.wb_valid(wb_valid),
	.stall(stall)
);

`default_nettype wire

// ==== dv/xm23_core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_core_checker
	import xm23_isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [15:0] instr,
	input logic instr_ack,
	input logic wb_valid,
	input logic [2:0] wb_reg,
	input logic [15:0] wb_data,
	input logic [3:0] psw,
	output int error_count,
	output int pending
);

	localparam logic [15:0] CONST_ROWS [8] = '{
		16'h0000, 16'h0001, 16'h0002, 16'h0004,
		16'h0008, 16'h0010, 16'h0020, 16'hffff
	};

	logic [15:0] model_regs [8];
	logic [3:0] model_psw;	// C Z N V
	logic [2:0] exp_reg [$];
	logic [15:0] exp_data [$];
	logic [3:0] exp_psw [$];
	logic ack_q;
	logic reset_q;

	// Sequential ISA model, one word per accepted handshake
	task automatic apply_word(input logic [15:0] w);
		logic [3:0] op;
		logic [2:0] dst;
		logic [15:0] d, s, r;
		logic [16:0] wide;
		logic [8:0] narrow;
		logic is_add, is_sub, is_alu, sets_flags, writes;
		logic sign_d, sign_s, sign_r, carry, zero;
		op = w[15:12];
		dst = w[2:0];
		d = model_regs[dst];
		s = w[11] ? CONST_ROWS[w[5:3]] : model_regs[w[5:3]];
		is_add = (op == OP_ADD);
		is_sub = (op == OP_SUB);
		is_alu = is_add || is_sub || op == OP_AND || op == OP_XOR || op == OP_MOV;
		sets_flags = is_alu && op != OP_MOV;
		writes = 1'b1;
		case (op)
			OP_ADD: r = d + s;
			OP_SUB: r = d - s;
			OP_AND: r = d & s;
			OP_XOR: r = d ^ s;
			OP_MOV: r = s;
			OP_SXT: r = {{8{d[7]}}, d[7:0]};
			OP_SWPB: r = {d[7:0], d[15:8]};
			OP_MOVL: r = {d[15:8], w[10:3]};
			OP_MOVH: r = {w[10:3], d[7:0]};
			default: begin
				r = d;
				writes = 1'b0;	// Undefined code
			end
		endcase
		if (is_alu && w[10])
			r = {d[15:8], r[7:0]};	// Byte op leaves the high byte
		wide = {1'b0, d} + {1'b0, s};
		narrow = {1'b0, d[7:0]} + {1'b0, s[7:0]};
		if (w[10]) begin
			sign_d = d[7];
			sign_s = s[7];
			sign_r = r[7];
			zero = (r[7:0] == 8'h00);
			carry = is_sub ? (d[7:0] >= s[7:0]) : narrow[8];	// SUB carry means no borrow
		end else begin
			sign_d = d[15];
			sign_s = s[15];
			sign_r = r[15];
			zero = (r == 16'h0000);
			carry = is_sub ? (d >= s) : wide[16];
		end
		if (sets_flags) begin
			model_psw[2] = zero;
			model_psw[1] = sign_r;
			if (is_add || is_sub) begin
				model_psw[3] = carry;
				model_psw[0] = is_add ? (sign_d == sign_s && sign_r != sign_d) :
					(sign_d != sign_s && sign_r != sign_d);
			end
		end
		if (writes) begin
			model_regs[dst] = r;
			exp_reg.push_back(dst);
			exp_data.push_back(r);
			exp_psw.push_back(model_psw);
		end
	endtask

	task automatic check_idle_state();
		if (wb_valid !== 1'b0 || instr_ack !== 1'b0 || psw !== 4'h0) begin
			$display("FAILED at %0t: after reset wb_valid=%b instr_ack=%b psw=%b, expected zeros",
				$time, wb_valid, instr_ack, psw);
			error_count++;
		end
	endtask

	task automatic compare_writeback();
		if (exp_reg.size() == 0) begin
			$display("Unexpected writeback at %0t: R%0d = %h with no instruction outstanding",
				$time, wb_reg, wb_data);
			error_count++;
		end else begin
			if (wb_reg !== exp_reg[0] || wb_data !== exp_data[0] || psw !== exp_psw[0]) begin
				$display("FAILED at %0t: got R%0d = %h psw %b, expected R%0d = %h psw %b",
					$time, wb_reg, wb_data, psw, exp_reg[0], exp_data[0], exp_psw[0]);
				error_count++;
			end
			void'(exp_reg.pop_front());
			void'(exp_data.pop_front());
			void'(exp_psw.pop_front());
		end
	endtask

	// Sampled before the edge updates, so all DUT outputs are settled
	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				model_regs[i] = '0;
			model_psw = '0;
			exp_reg.delete();
			exp_data.delete();
			exp_psw.delete();
			error_count = 0;
		end else begin
			if (reset_q)
				check_idle_state();
			if (instr_ack && !ack_q)
				apply_word(instr);	// Word still held by the source
			if (wb_valid)
				compare_writeback();
		end
		pending = exp_reg.size();
		ack_q <= instr_ack;
		reset_q <= reset;
	end

endmodule

`default_nettype wire

// ==== dv/xm23_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module xm23_core_tb
	import xm23_isa_pkg::*, xm23_core_pkg::*;
();

	localparam int NUM_WORDS = 600;
	localparam int WAIT_LIMIT = 64;	// Cycles per handshake phase

	// Opcode mix with three no-op codes out of sixteen
	localparam logic [3:0] OP_POOL [16] = '{
		4'h4, 4'h4, 4'h5, 4'h5, 4'h6, 4'h7, 4'h8, 4'h9,
		4'ha, 4'hc, 4'hc, 4'hd, 4'hd, 4'h0, 4'hb, 4'hf
	};

	logic clock;
	logic reset;
	instr_t instr;
	logic instr_req;
	logic instr_ack;
	logic wb_valid;
	reg_num_t wb_reg;
	word_t wb_data;
	psw_t psw;
	integer seed;
	int timeouts;
	int error_count;
	int pending;
	reg_num_t last_dst;

	always #20 clock = ~clock;

	xm23_core dut0 (
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.instr_req(instr_req),
		.instr_ack(instr_ack),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.psw(psw)
	);

	xm23_core_checker checker0 (
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.instr_ack(instr_ack),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.psw(psw),
		.error_count(error_count),
		.pending(pending)
	);

	// Half of the words read the register written just before
	function automatic instr_t random_word();
		logic [31:0] r;
		logic [3:0] op;
		reg_num_t dst;
		reg_num_t src;
		r = $random(seed);
		op = OP_POOL[r[3:0]];
		dst = r[6:4];
		src = r[10] ? last_dst : r[9:7];
		last_dst = dst;
		if (op == OP_MOVL || op == OP_MOVH)
			return {op, 1'b0, r[20:13], dst};
		return {op, r[11], r[12], 4'b0000, src, dst};	// RC and byte bits random
	endfunction

	task automatic send_word(input instr_t word);
		int waited;
		@(negedge clock);
		instr = word;
		instr_req = 1'b1;
		waited = 0;
		while (!instr_ack && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!instr_ack) begin
			$display("Timeout at %0t: instruction %h was never acknowledged", $time, word);
			timeouts++;
		end
		instr_req = 1'b0;
		waited = 0;
		while (instr_ack && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (instr_ack) begin
			$display("Timeout at %0t: instr_ack stayed high after the request dropped", $time);
			timeouts++;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending != 0 && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (pending != 0) begin
			$display("Timeout at %0t: %0d expected writebacks never arrived", $time, pending);
			timeouts++;
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		instr = '0;
		instr_req = 1'b0;
		seed = 32'hbd8c;
		timeouts = 0;
		last_dst = '0;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < NUM_WORDS; i++)
			send_word(random_word());
		wait_drain();
		repeat (8) @(negedge clock);	// Window for stray writebacks
		$display("Errors: %0d, timeouts: %0d, assertion failures: %0d", error_count, timeouts,
			dut0.sva0.fail_count);
		if (error_count == 0 && timeouts == 0 && dut0.sva0.fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== xm23_pipe.f ====
+incdir+design
design/xm23_isa_pkg.sv
design/xm23_core_pkg.sv
design/xm23_stage_reg.sv
design/xm23_fetch.sv
design/xm23_decode.sv
design/xm23_execute.sv
design/xm23_reg_file.sv
design/xm23_core.sv
dv/xm23_core_sva.sv
dv/xm23_core_checker.sv
dv/xm23_core_tb.sv

// ==== Makefile ====
# Build and run the xm23 pipeline testbench with Verilator

sim:
	verilator --binary --timing --assert -f xm23_pipe.f --top-module xm23_core_tb -o xm23_sim
	./obj_dir/xm23_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
